// ==== Makefile ====
SIM     = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = fei4_rx_tb
FLIST   = flist.f
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
SRCS    = $(shell grep '\.sv$$' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== fei4_rx_tb.sv ====
`default_nettype none
`timescale 1ns/10ps

module fei4_rx_tb
    import rx_types_pkg::*, rx_regmap_pkg::*;
();

    localparam rx_byte_t ID           = 8'hA5;
    localparam int       SYNC_COMMAS  = 4;
    localparam int       ADDR_BITS    = 4;
    localparam int       DEPTH        = 2 ** ADDR_BITS;
    localparam int       RESET_CYCLES = 8;
    localparam int       N_WORDS      = 4;
    localparam int       N_INV        = 2;
    localparam int       N_BAD        = 3;
    localparam int       N_EXTRA      = 3;  // words past a full FIFO
    localparam int       N_CODES      = 8;
    localparam symbol_t  K28_5        = 10'b0011111010;

    // symbol cycles of all tests, 24 bus accesses at 3 cycles, settle gaps and margin
    localparam int SYMBOLS = 2 * SYNC_COMMAS + 3 * N_WORDS + 3 * N_INV + N_BAD
                           + 3 * (DEPTH + N_EXTRA) + 4;
    localparam int TIMEOUT = RESET_CYCLES + SYMBOLS + 3 * 24 + 150;

    // rd- column; an unbalanced 6b group is followed by the rd+ 4b group
    rx_byte_t code_byte [N_CODES] = '{8'h00, 8'h4A, 8'hB5, 8'h3C,
                                      8'hFF, 8'h13, 8'hE7, 8'h65};
    symbol_t  code_sym  [N_CODES] = '{10'b1001110100, 10'b0101010101,   // D0.0 D10.2
                                      10'b1010101010, 10'b0011101001,   // D21.5 D28.1
                                      10'b1010110001, 10'b1100101011,   // D31.7 D19.0
                                      10'b1110001110, 10'b1010011100};  // D7.7 D5.3

    logic     BUS_CLK;
    logic     RST;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_i;
    logic     [3:0] wb_sel;
    wb_data_t wb_dat_o;
    logic     wb_ack;
    symbol_t  symbol;
    logic     symbol_valid;
    logic     rx_ready;
    logic     rx_decoder_err;
    logic     rx_fifo_overflow_err;
    logic     rx_fifo_full;

    integer   seed;
    int       errors;
    int       tests_run;
    int       tests_failed;

    tb_clk_gen #(.PERIOD_NS(4.0)) i_clk (.clk(BUS_CLK));

    fei4_rx_top #(
        .DATA_IDENTIFIER(ID),
        .FIFO_ADDR_BITS(ADDR_BITS),
        .SYNC_COMMAS(SYNC_COMMAS)
    ) i_dut (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i),
        .wb_sel(wb_sel),
        .wb_dat_o(wb_dat_o),
        .wb_ack(wb_ack),
        .symbol(symbol),
        .symbol_valid(symbol_valid),
        .rx_ready(rx_ready),
        .rx_decoder_err(rx_decoder_err),
        .rx_fifo_overflow_err(rx_fifo_overflow_err),
        .rx_fifo_full(rx_fifo_full)
    );

    task automatic check_word(input fe_word_t got, input fe_word_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is 0x%06h, expected 0x%06h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input err_cnt_t got, input err_cnt_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_level(input fifo_level_t got, input fifo_level_t exp,
                               input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bus(input wb_data_t got, input wb_data_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            errors++;
        end
    endtask

    // one classic cycle, starts and ends on a falling edge
    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = wdata;
        wb_sel   = 4'hF;
        @(negedge BUS_CLK);
        while (!wb_ack && waited < 8) begin
            waited++;
            @(negedge BUS_CLK);
        end
        if (!wb_ack) begin
            $display("no Wishbone ack for address %0d at %0t ns", adr, $time);
            errors++;
        end
        rdata  = wb_dat_o;  // valid while ack is high
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t data);
        wb_data_t unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t data);
        bus_cycle(1'b0, adr, 32'h0, data);
    endtask

    task automatic send_symbol(input symbol_t s);
        symbol       = s;
        symbol_valid = 1'b1;
        @(negedge BUS_CLK);
        symbol_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge BUS_CLK);
    endtask

    // three table bytes, first one ends up in the top byte of the word
    task automatic send_random_word(input logic invert, output fe_word_t w);
        int idx;
        for (int i = 0; i < 3; i++) begin
            idx = $unsigned($random(seed)) % N_CODES;
            w   = {w[15:0], code_byte[idx]};
            send_symbol(invert ? ~code_sym[idx] : code_sym[idx]);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d check(s) failed", name, errors - errors_before);
        end
    endtask

    task automatic read_words(input fe_word_t exp_q[$]);
        wb_data_t d;
        fe_word_t w;
        while (exp_q.size() > 0) begin
            w = exp_q.pop_front();
            wb_read(ADDR_FIFO_DATA, d);
            check_bus({d[31:24], 24'h0}, {ID, 24'h0}, "word identifier");
            check_word(d[23:0], w, "FIFO word");
        end
    endtask

    task automatic test_reset_state();
        wb_data_t d;
        int e0;
        e0 = errors;
        wb_read(ADDR_VERSION, d);
        check_bus(d, 32'd2, "version");
        check_bus(wb_data_t'(rx_ready), 32'd0, "rx_ready after reset");
        wb_read(ADDR_FIFO_SIZE, d);
        check_level(d[15:0], 16'd0, "FIFO size after reset");
        end_test("reset state", e0);
    endtask

    task automatic test_sync();
        wb_data_t d;
        int e0;
        e0 = errors;
        repeat (SYNC_COMMAS - 1) send_symbol(K28_5);
        send_symbol(code_sym[1]);  // restarts the count
        repeat (SYNC_COMMAS - 1) send_symbol(K28_5);
        idle_cycles(2);
        check_bus(wb_data_t'(rx_ready), 32'd0, "rx_ready short of the comma count");
        wb_read(ADDR_CTRL, d);
        check_bus(d, 32'h0, "ctrl before lock");
        send_symbol(K28_5);
        idle_cycles(1);
        check_bus(wb_data_t'(rx_ready), 32'd1, "rx_ready after lock");
        wb_read(ADDR_CTRL, d);
        check_bus(d, 32'h1, "ctrl ready bit");
        end_test("sync", e0);
    endtask

    task automatic test_data_path();
        wb_data_t d;
        fe_word_t w;
        fe_word_t exp_q[$];
        int e0;
        e0 = errors;
        send_symbol(K28_5);  // word alignment
        repeat (N_WORDS) begin
            send_random_word(1'b0, w);
            exp_q.push_back(w);
        end
        idle_cycles(3);
        wb_read(ADDR_FIFO_SIZE, d);
        check_level(d[15:0], fifo_level_t'(N_WORDS), "FIFO size after data");
        read_words(exp_q);
        wb_read(ADDR_FIFO_SIZE, d);
        check_level(d[15:0], 16'd0, "FIFO size after reading");
        end_test("data path", e0);
    endtask

    task automatic test_inversion();
        wb_data_t d;
        fe_word_t w;
        fe_word_t exp_q[$];
        int e0;
        e0 = errors;
        wb_write(ADDR_CTRL, 32'h2);
        wb_read(ADDR_CTRL, d);
        check_bus(d, 32'h3, "ctrl with inversion");
        send_symbol(~K28_5);
        repeat (N_INV) begin
            send_random_word(1'b1, w);
            exp_q.push_back(w);
        end
        idle_cycles(3);
        read_words(exp_q);
        wb_write(ADDR_CTRL, 32'h0);
        end_test("inversion", e0);
    endtask

    task automatic test_errors();
        wb_data_t d;
        fe_word_t w;
        int e0;
        e0 = errors;
        repeat (N_BAD) send_symbol(10'h000);  // no valid 6b group
        idle_cycles(2);
        wb_read(ADDR_DEC_ERR, d);
        check_count(d[7:0], err_cnt_t'(N_BAD), "decoder error count");
        check_bus(wb_data_t'(rx_decoder_err), 32'd1, "rx_decoder_err");
        send_symbol(K28_5);
        repeat (DEPTH + N_EXTRA) send_random_word(1'b0, w);
        idle_cycles(3);
        wb_read(ADDR_FIFO_SIZE, d);
        check_level(d[15:0], fifo_level_t'(DEPTH), "FIFO size when full");
        wb_read(ADDR_LOST_ERR, d);
        check_count(d[7:0], err_cnt_t'(N_EXTRA), "lost word count");
        check_bus(wb_data_t'(rx_fifo_overflow_err), 32'd1, "rx_fifo_overflow_err");
        check_bus(wb_data_t'(rx_fifo_full), 32'd1, "rx_fifo_full");
        end_test("errors", e0);
    endtask

    task automatic test_soft_reset();
        wb_data_t d;
        int e0;
        e0 = errors;
        wb_write(ADDR_CTRL, 32'h2);
        wb_write(ADDR_VERSION, 32'h0);
        idle_cycles(2);  // reset pulse reaches the datapath
        wb_read(ADDR_CTRL, d);
        check_bus(d, 32'h0, "ctrl after soft reset");
        wb_read(ADDR_DEC_ERR, d);
        check_count(d[7:0], 8'd0, "decoder errors after soft reset");
        wb_read(ADDR_LOST_ERR, d);
        check_count(d[7:0], 8'd0, "lost words after soft reset");
        wb_read(ADDR_FIFO_SIZE, d);
        check_level(d[15:0], 16'd0, "FIFO size after soft reset");
        check_bus(wb_data_t'(rx_ready), 32'd0, "rx_ready after soft reset");
        check_bus(wb_data_t'(rx_decoder_err), 32'd0, "rx_decoder_err after soft reset");
        end_test("soft reset", e0);
    endtask

    initial begin
        seed         = 32'hbc41764f;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        RST          = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_i     = '0;
        wb_sel       = 4'h0;
        symbol       = '0;
        symbol_valid = 1'b0;
        repeat (RESET_CYCLES) @(negedge BUS_CLK);
        RST = 1'b0;
        test_reset_state();
        test_sync();
        test_data_path();
        test_inversion();
        test_errors();
        test_soft_reset();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        repeat (TIMEOUT) @(posedge BUS_CLK);
        $display("watchdog expired after %0d cycles, run did not complete", TIMEOUT);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== fei4_rx_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module fei4_rx_top
    import rx_types_pkg::*, rx_regmap_pkg::*;
#(
    parameter rx_byte_t DATA_IDENTIFIER = 8'h00,
    parameter int       FIFO_ADDR_BITS  = 4,
    parameter int       SYNC_COMMAS     = 4
) (
    input  wire           BUS_CLK,
    input  wire           RST,
    input  wire           wb_cyc,
    input  wire           wb_stb,
    input  wire           wb_we,
    input  wire wb_addr_t wb_adr,
    input  wire wb_data_t wb_dat_i,
    input  wire [3:0]     wb_sel,
    output wb_data_t      wb_dat_o,
    output logic          wb_ack,
    input  wire symbol_t  symbol,
    input  wire           symbol_valid,
    output logic          rx_ready,
    output logic          rx_decoder_err,
    output logic          rx_fifo_overflow_err,
    output logic          rx_fifo_full
);

    logic        rx_rst;
    logic        invert_rx_data;
    rx_byte_t    rx_byte;
    logic        byte_valid;
    logic        comma_seen;
    err_cnt_t    dec_err_cnt;
    fe_word_t    rd_data;
    logic        rd_en;
    logic        empty;
    fifo_level_t fill_level;
    err_cnt_t    lost_cnt;

    // decode
    rx_symbol_decoder #(
        .SYNC_COMMAS(SYNC_COMMAS)
    ) i_decoder (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .rx_rst(rx_rst),
        .symbol(symbol),
        .symbol_valid(symbol_valid),
        .invert_rx_data(invert_rx_data),
        .rx_byte(rx_byte),
        .byte_valid(byte_valid),
        .comma_seen(comma_seen),
        .ready(rx_ready),
        .dec_err_cnt(dec_err_cnt)
    );

    // execute
    rx_word_fifo #(
        .FIFO_ADDR_BITS(FIFO_ADDR_BITS)
    ) i_fifo (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .rx_rst(rx_rst),
        .rx_byte(rx_byte),
        .byte_valid(byte_valid),
        .comma_seen(comma_seen),
        .rd_en(rd_en),
        .rd_data(rd_data),
        .empty(empty),
        .full(rx_fifo_full),
        .fill_level(fill_level),
        .lost_cnt(lost_cnt)
    );

    // result
    rx_wb_regs #(
        .DATA_IDENTIFIER(DATA_IDENTIFIER)
    ) i_regs (
        .BUS_CLK(BUS_CLK),
        .RST(RST),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i),
        .wb_sel(wb_sel),
        .ready(rx_ready),
        .dec_err_cnt(dec_err_cnt),
        .rd_data(rd_data),
        .empty(empty),
        .fill_level(fill_level),
        .lost_cnt(lost_cnt),
        .wb_dat_o(wb_dat_o),
        .wb_ack(wb_ack),
        .rx_rst(rx_rst),
        .invert_rx_data(invert_rx_data),
        .rd_en(rd_en),
        .decoder_err(rx_decoder_err),
        .overflow_err(rx_fifo_overflow_err)
    );

endmodule

`default_nettype wire

// ==== flist.f ====
rx_types_pkg.sv
rx_regmap_pkg.sv
rx_symbol_decoder.sv
rx_word_fifo.sv
rx_wb_regs.sv
fei4_rx_top.sv
tb_clk_gen.sv
fei4_rx_tb.sv

// ==== rx_regmap_pkg.sv ====
`default_nettype none

package rx_regmap_pkg;

    typedef logic [3:0]  wb_addr_t;  // word address
    typedef logic [31:0] wb_data_t;

    localparam wb_addr_t ADDR_VERSION   = 4'd0;  // read version, write soft reset
    localparam wb_addr_t ADDR_RX_RESET  = 4'd1;  // receiver only
    localparam wb_addr_t ADDR_CTRL      = 4'd2;  // bit 1 invert, bit 0 reads ready
    localparam wb_addr_t ADDR_FIFO_SIZE = 4'd3;
    localparam wb_addr_t ADDR_DEC_ERR   = 4'd4;
    localparam wb_addr_t ADDR_LOST_ERR  = 4'd5;
    localparam wb_addr_t ADDR_FIFO_DATA = 4'd6;  // pops one word per read

    localparam wb_data_t RX_VERSION = 32'd2;

endpackage

`default_nettype wire

// ==== rx_symbol_decoder.sv ====
`default_nettype none
`timescale 1ns/10ps

module rx_symbol_decoder
    import rx_types_pkg::*;
#(
    parameter int SYNC_COMMAS = 4
) (
    input  wire          BUS_CLK,
    input  wire          RST,
    input  wire          rx_rst,
    input  wire symbol_t symbol,
    input  wire          symbol_valid,
    input  wire          invert_rx_data,
    output rx_byte_t     rx_byte,
    output logic         byte_valid,
    output logic         comma_seen,
    output logic         ready,
    output err_cnt_t     dec_err_cnt
);

    localparam int CW = $clog2(SYNC_COMMAS + 1);
    localparam logic [CW-1:0] LAST_COMMA = CW'(SYNC_COMMAS - 1);

    typedef enum logic {HUNT, LOCKED} sync_state_t;

    sync_state_t   state;
    logic [CW-1:0] comma_cnt;
    symbol_t       sym;
    logic [5:0]    dec6;  // {ok, EDCBA}
    logic [3:0]    dec4;  // {ok, HGF}
    logic          is_comma;
    logic          data_ok;

    // abcdei -> EDCBA, both disparities
    function automatic logic [5:0] lookup_6b(input logic [5:0] abcdei);
        logic [5:0] r;
        case (abcdei)
            6'b100111, 6'b011000: r = {1'b1, 5'd0};
            6'b011101, 6'b100010: r = {1'b1, 5'd1};
            6'b101101, 6'b010010: r = {1'b1, 5'd2};
            6'b110001:            r = {1'b1, 5'd3};
            6'b110101, 6'b001010: r = {1'b1, 5'd4};
            6'b101001:            r = {1'b1, 5'd5};
            6'b011001:            r = {1'b1, 5'd6};
            6'b111000, 6'b000111: r = {1'b1, 5'd7};
            6'b111001, 6'b000110: r = {1'b1, 5'd8};
            6'b100101:            r = {1'b1, 5'd9};
            6'b010101:            r = {1'b1, 5'd10};
            6'b110100:            r = {1'b1, 5'd11};
            6'b001101:            r = {1'b1, 5'd12};
            6'b101100:            r = {1'b1, 5'd13};
            6'b011100:            r = {1'b1, 5'd14};
            6'b010111, 6'b101000: r = {1'b1, 5'd15};
            6'b011011, 6'b100100: r = {1'b1, 5'd16};
            6'b100011:            r = {1'b1, 5'd17};
            6'b010011:            r = {1'b1, 5'd18};
            6'b110010:            r = {1'b1, 5'd19};
            6'b001011:            r = {1'b1, 5'd20};
            6'b101010:            r = {1'b1, 5'd21};
            6'b011010:            r = {1'b1, 5'd22};
            6'b111010, 6'b000101: r = {1'b1, 5'd23};
            6'b110011, 6'b001100: r = {1'b1, 5'd24};
            6'b100110:            r = {1'b1, 5'd25};
            6'b010110:            r = {1'b1, 5'd26};
            6'b110110, 6'b001001: r = {1'b1, 5'd27};
            6'b001110:            r = {1'b1, 5'd28};
            6'b101110, 6'b010001: r = {1'b1, 5'd29};
            6'b011110, 6'b100001: r = {1'b1, 5'd30};
            6'b101011, 6'b010100: r = {1'b1, 5'd31};
            default:              r = 6'b0;  // K28 and illegal groups
        endcase
        return r;
    endfunction

    // fghj -> HGF, primary and alternate 7
    function automatic logic [3:0] lookup_4b(input logic [3:0] fghj);
        logic [3:0] r;
        case (fghj)
            4'b1011, 4'b0100:                   r = {1'b1, 3'd0};
            4'b1001:                            r = {1'b1, 3'd1};
            4'b0101:                            r = {1'b1, 3'd2};
            4'b1100, 4'b0011:                   r = {1'b1, 3'd3};
            4'b1101, 4'b0010:                   r = {1'b1, 3'd4};
            4'b1010:                            r = {1'b1, 3'd5};
            4'b0110:                            r = {1'b1, 3'd6};
            4'b1110, 4'b0001, 4'b0111, 4'b1000: r = {1'b1, 3'd7};
            default:                            r = 4'b0;
        endcase
        return r;
    endfunction

    assign sym      = invert_rx_data ? ~symbol : symbol;
    assign dec6     = lookup_6b(sym[9:4]);
    assign dec4     = lookup_4b(sym[3:0]);
    assign is_comma = (sym == COMMA_RD_NEG) || (sym == COMMA_RD_POS);
    assign data_ok  = dec6[5] && dec4[3];
    assign ready    = (state == LOCKED);

    always_ff @(posedge BUS_CLK) begin
        if (RST || rx_rst) begin
            state       <= HUNT;
            comma_cnt   <= '0;
            byte_valid  <= 1'b0;
            comma_seen  <= 1'b0;
            dec_err_cnt <= '0;
        end else begin
            byte_valid <= symbol_valid && ready && data_ok;
            comma_seen <= symbol_valid && ready && is_comma;
            if (symbol_valid) begin
                case (state)
                    HUNT: begin
                        if (!is_comma)
                            comma_cnt <= '0;  // must be consecutive
                        else if (comma_cnt == LAST_COMMA)
                            state <= LOCKED;
                        else
                            comma_cnt <= comma_cnt + 1'b1;
                    end
                    LOCKED: begin
                        if (!data_ok && !is_comma && dec_err_cnt != ERR_CNT_MAX)
                            dec_err_cnt <= dec_err_cnt + 1'b1;
                    end
                    default: state <= HUNT;
                endcase
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (symbol_valid && data_ok)
            rx_byte <= {dec4[2:0], dec6[4:0]};
    end

    assert property (@(posedge BUS_CLK) disable iff (RST) !(byte_valid && comma_seen))
        else $error("byte_valid and comma_seen high together");

endmodule

`default_nettype wire

// ==== rx_types_pkg.sv ====
`default_nettype none

package rx_types_pkg;

    typedef logic [9:0]  symbol_t;     // one 8b10b code group, bit 9 is 'a' (first on the wire)
    typedef logic [7:0]  rx_byte_t;    // decoded byte, HGF EDCBA
    typedef logic [23:0] fe_word_t;    // three bytes, first one in [23:16]
    typedef logic [7:0]  err_cnt_t;    // saturates at 255
    typedef logic [15:0] fifo_level_t;

    // K28.5 comma, both running disparities
    localparam symbol_t COMMA_RD_NEG = 10'b0011111010;
    localparam symbol_t COMMA_RD_POS = 10'b1100000101;

    localparam int BYTES_PER_WORD = 3;
    localparam err_cnt_t ERR_CNT_MAX = 8'hFF;

endpackage

`default_nettype wire

// ==== rx_wb_regs.sv ====
`default_nettype none
`timescale 1ns/10ps

module rx_wb_regs
    import rx_types_pkg::*, rx_regmap_pkg::*;
#(
    parameter rx_byte_t DATA_IDENTIFIER = 8'h00
) (
    input  wire              BUS_CLK,
    input  wire              RST,
    input  wire              wb_cyc,
    input  wire              wb_stb,
    input  wire              wb_we,
    input  wire wb_addr_t    wb_adr,
    input  wire wb_data_t    wb_dat_i,
    input  wire [3:0]        wb_sel,
    input  wire              ready,
    input  wire err_cnt_t    dec_err_cnt,
    input  wire fe_word_t    rd_data,
    input  wire              empty,
    input  wire fifo_level_t fill_level,
    input  wire err_cnt_t    lost_cnt,
    output wb_data_t         wb_dat_o,
    output logic             wb_ack,
    output logic             rx_rst,
    output logic             invert_rx_data,
    output logic             rd_en,
    output logic             decoder_err,
    output logic             overflow_err
);

    logic       req;
    logic       wr_req;
    logic       rd_req;
    logic [7:1] ctrl;  // bit 0 position reads back ready
    wb_data_t   rd_mux;

    // no new request while ack is out, stb is still high then
    assign req    = wb_cyc && wb_stb && !wb_ack;
    assign wr_req = req && wb_we;
    assign rd_req = req && !wb_we;

    // pop on the same edge that raises ack
    assign rd_en = rd_req && (wb_adr == ADDR_FIFO_DATA) && !empty;

    assign invert_rx_data = ctrl[1];
    assign decoder_err    = (dec_err_cnt != '0);
    assign overflow_err   = (lost_cnt != '0);

    always_comb begin
        case (wb_adr)
            ADDR_VERSION:   rd_mux = RX_VERSION;
            ADDR_CTRL:      rd_mux = {24'b0, ctrl, ready};
            ADDR_FIFO_SIZE: rd_mux = {16'b0, fill_level};
            ADDR_DEC_ERR:   rd_mux = {24'b0, dec_err_cnt};
            ADDR_LOST_ERR:  rd_mux = {24'b0, lost_cnt};
            ADDR_FIFO_DATA: rd_mux = {DATA_IDENTIFIER, empty ? 24'b0 : rd_data};
            default:        rd_mux = '0;
        endcase
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wb_ack <= 1'b0;
            rx_rst <= 1'b0;
        end else begin
            wb_ack <= req;
            // soft reset and receiver reset both clear the datapath
            rx_rst <= wr_req && (wb_adr == ADDR_VERSION || wb_adr == ADDR_RX_RESET);
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST || (wr_req && wb_adr == ADDR_VERSION))
            ctrl <= '0;
        else if (wr_req && wb_adr == ADDR_CTRL && wb_sel[0])
            ctrl <= wb_dat_i[7:1];
    end

    always_ff @(posedge BUS_CLK) begin
        if (rd_req)
            wb_dat_o <= rd_mux;  // held through the ack cycle
    end

    assert property (@(posedge BUS_CLK) disable iff (RST) wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles");

endmodule

`default_nettype wire

// ==== rx_word_fifo.sv ====
`default_nettype none
`timescale 1ns/10ps

module rx_word_fifo
    import rx_types_pkg::*;
#(
    parameter int FIFO_ADDR_BITS = 4
) (
    input  wire           BUS_CLK,
    input  wire           RST,
    input  wire           rx_rst,
    input  wire rx_byte_t rx_byte,
    input  wire           byte_valid,
    input  wire           comma_seen,
    input  wire           rd_en,
    output fe_word_t      rd_data,
    output logic          empty,
    output logic          full,
    output fifo_level_t   fill_level,
    output err_cnt_t      lost_cnt
);

    localparam int DEPTH = 2 ** FIFO_ADDR_BITS;
    localparam logic [1:0] LAST_POS = 2'(BYTES_PER_WORD - 1);

    fe_word_t                  mem [DEPTH];
    fe_word_t                  word_sr;  // packing shift register
    logic [1:0]                byte_pos;
    logic                      wr_pending;
    logic                      do_wr;
    logic [FIFO_ADDR_BITS-1:0] wr_ptr;
    logic [FIFO_ADDR_BITS-1:0] rd_ptr;

    assign full    = (fill_level == fifo_level_t'(DEPTH));
    assign empty   = (fill_level == '0);
    assign do_wr   = wr_pending && !full;
    assign rd_data = mem[rd_ptr];  // first word falls through

    always_ff @(posedge BUS_CLK) begin
        if (RST || rx_rst) begin
            byte_pos   <= '0;
            wr_pending <= 1'b0;
        end else begin
            wr_pending <= 1'b0;
            if (comma_seen) begin
                byte_pos <= '0;  // realign to the first byte
            end else if (byte_valid) begin
                if (byte_pos == LAST_POS) begin
                    byte_pos   <= '0;
                    wr_pending <= 1'b1;
                end else begin
                    byte_pos <= byte_pos + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (byte_valid)
            word_sr <= {word_sr[15:0], rx_byte};
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST || rx_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_level <= '0;
            lost_cnt   <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_wr && !rd_en)
                fill_level <= fill_level + 1'b1;
            else if (rd_en && !do_wr)
                fill_level <= fill_level - 1'b1;
            if (wr_pending && full && lost_cnt != ERR_CNT_MAX)
                lost_cnt <= lost_cnt + 1'b1;  // word dropped
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (do_wr)
            mem[wr_ptr] <= word_sr;
    end

    assert property (@(posedge BUS_CLK) disable iff (RST) rd_en |-> !empty)
        else $error("pop from empty word FIFO");

    assert property (@(posedge BUS_CLK) disable iff (RST)
                     fill_level <= fifo_level_t'(DEPTH))
        else $error("fill level above FIFO depth");

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2.0) clk = ~clk;  // free running

endmodule

`default_nettype wire
